//--- fetchSubsystem.f
verilog/fetchPkg.sv
verilog/sramIf.sv
verilog/fetchIf.sv
verilog/instructionFetch.sv
verilog/instSram.sv
verilog/jumpPredecoder.sv
verilog/fetchSubsystem.sv
verification/fetchSubsystemTb.sv

//--- run.sh
#!/bin/sh
# build with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module fetchSubsystemTb -f fetchSubsystem.f -o fetchSim > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/fetchSim > sim.log 2>&1
cat sim.log

grep -qxF "** PASS **" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- verification/fetchSubsystemTb.sv
`timescale 1ns/10ps

module fetchSubsystemTb;
    import fetchPkg::*;

    localparam int numTests = 7;

    logic        clk;
    logic        reset;
    logic        pcStall;
    logic        redirect;
    logic [31:0] redirectAddress;
    logic [31:0] fetchPc;
    logic [31:0] fetchInstruction;
    logic        fetchValid;
    logic        fetchException;

    // test table, one row per test
    string       testName [numTests];
    int          deliveries [numTests];
    // delivery counts that start a stall or arm the redirect, -1 when unused
    int          stallAt [numTests];
    int          redirectAt [numTests];
    int          redirectDelay [numTests];
    logic [31:0] redirectTo [numTests];
    logic [31:0] lastPc [numTests];
    int          rows;

    logic [31:0] image [memWords];
    logic [31:0] expPc [$];
    int          seed;
    int          cycles;
    int          cycleLimit;
    int          checks;
    int          errors;
    int          failedTests;

    fetchSubsystem uut (
        .clk              (clk),
        .reset            (reset),
        .pcStall          (pcStall),
        .redirect         (redirect),
        .redirectAddress  (redirectAddress),
        .fetchPc          (fetchPc),
        .fetchInstruction (fetchInstruction),
        .fetchValid       (fetchValid),
        .fetchException   (fetchException)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= cycleLimit) begin
            $display("timeout after %0d cycles, the expected deliveries never arrived", cycles);
            $display("** FAIL **");
            $finish;
        end
    end

    task automatic addTest(input string name, input int n, input int stall, input int redir,
                           input int delay, input logic [31:0] target,
                           input logic [31:0] last);
        testName[rows] = name;
        deliveries[rows] = n;
        stallAt[rows] = stall;
        redirectAt[rows] = redir;
        redirectDelay[rows] = delay;
        redirectTo[rows] = target;
        lastPc[rows] = last;
        rows++;
    endtask

    // walk the program image by the fetch rules to get the delivered pcs
    task automatic buildExpected(input int t);
        logic [31:0] pc;
        logic [31:0] word;
        logic [31:0] slotPc;
        logic [31:0] target;
        logic        inDelaySlot;
        logic        redirected;
        opcodeT      opcode;
        pc = resetVector;
        target = 32'd0;
        inDelaySlot = 1'b0;
        redirected = 1'b0;
        expPc.delete();
        for (int i = 0; i < deliveries[t]; i++) begin
            expPc.push_back(pc);
            word = image[pc[11:2]];
            opcode = opcodeT'(word[31:26]);
            slotPc = pc + 32'd4;
            if (redirectAt[t] >= 0 && !redirected && (i == redirectAt[t] ||
                    (i == redirectAt[t] - 1 && word == waitInstruction))) begin
                // one word still slips through before a redirect, none once hung
                redirected = 1'b1;
                pc = redirectTo[t];
            end else if (inDelaySlot) begin
                inDelaySlot = 1'b0;
                pc = target;
            end else if (opcode == opJ || opcode == opJal) begin
                inDelaySlot = 1'b1;
                target = {slotPc[31:28], word[25:0], 2'b00};
                pc = slotPc;
            end else begin
                pc = slotPc;
            end
        end
    endtask

    task automatic checkDelivery(input int t, input int index);
        logic [31:0] pc;
        logic [31:0] word;
        logic        exc;
        pc = expPc[index];
        word = image[pc[11:2]];
        exc = (pc[1:0] != 2'b00);
        checks += 3;
        assert (fetchPc == pc) else begin
            $display("ERR %s delivery %0d pc expected %h actual %h",
                     testName[t], index, pc, fetchPc);
            errors++;
        end
        assert (fetchInstruction == word) else begin
            $display("ERR %s delivery %0d instruction expected %h actual %h",
                     testName[t], index, word, fetchInstruction);
            errors++;
        end
        assert (fetchException == exc) else begin
            $display("ERR %s delivery %0d exception expected %0b actual %0b",
                     testName[t], index, exc, fetchException);
            errors++;
        end
    endtask

    task automatic runTest(input int t);
        int          seen;
        int          stallLeft;
        int          countdown;
        int          errorsBefore;
        logic [31:0] finalPc;
        seen = 0;
        stallLeft = 0;
        countdown = -1;
        errorsBefore = errors;
        finalPc = 32'd0;
        buildExpected(t);
        reset = 1'b1;
        pcStall = 1'b0;
        redirect = 1'b0;
        redirectAddress = redirectTo[t];
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        while (seen < deliveries[t]) begin
            @(posedge clk);
            #1;
            if (fetchValid) begin
                checkDelivery(t, seen);
                finalPc = fetchPc;
                seen++;
                if (seen == stallAt[t]) begin
                    stallLeft = 1 + ({$random(seed)} % 4);
                end
                if (seen == redirectAt[t]) begin
                    countdown = redirectDelay[t];
                end
            end
            pcStall = (stallLeft > 0);
            if (stallLeft > 0) begin
                stallLeft--;
            end
            // redirect is a single-cycle pulse
            redirect = (countdown == 0);
            if (countdown >= 0) begin
                countdown--;
            end
        end
        checks++;
        assert (finalPc == lastPc[t]) else begin
            $display("ERR %s final pc expected %h actual %h", testName[t], lastPc[t], finalPc);
            errors++;
        end
        if (errors == errorsBefore) begin
            $display("test %s: %0d deliveries ok", testName[t], seen);
        end else begin
            failedTests++;
            $display("test %s: %0d errors", testName[t], errors - errorsBefore);
        end
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        pcStall = 1'b0;
        redirect = 1'b0;
        redirectAddress = 32'd0;
        seed = 39079;
        cycles = 0;
        checks = 0;
        errors = 0;
        failedTests = 0;
        rows = 0;
        $readmemh("verification/program.hex", image);

        //      name              n   stall redir delay  target          last pc
        addTest("sequence",       20, -1,   -1,   0,     32'h0000_0000,  32'hBFC0_004C);
        addTest("jumpDelaySlot",  33, -1,   -1,   0,     32'h0000_0000,  32'hBFC0_0190);
        addTest("stallDelaySlot", 28, 21,   -1,   0,     32'h0000_0000,  32'hBFC0_0114);
        addTest("stallLineFill",  22, 15,   -1,   0,     32'h0000_0000,  32'hBFC0_0054);
        addTest("redirectFar",    11, -1,   6,    0,     32'hBFC0_0200,  32'hBFC0_020C);
        addTest("misalignedPc",   7,  -1,   3,    0,     32'hBFC0_0202,  32'hBFC0_020A);
        addTest("hangWake",       36, -1,   33,   8,     32'hBFC0_0210,  32'hBFC0_0218);

        cycleLimit = 20 * rows;
        for (int t = 0; t < rows; t++) begin
            cycleLimit += 4 * deliveries[t];
        end

        for (int t = 0; t < rows; t++) begin
            runTest(t);
        end

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 rows, failedTests, checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- verification/program.hex
// one 32-bit instruction word per line, in hex
// @nnn sets the word index (address bits 11:2) of the lines that follow
@000
24080000
24080001
24080002
24080003
24080004
24080005
24080006
24080007
24080008
24080009
2408000A
2408000B
2408000C
2408000D
2408000E
2408000F
24080010
24080011
24080012
24080013
0BF00040
24080015
24080016
@040
24080040
24080041
24080042
24080043
0FF00060
24080045
24080046
@060
24080060
24080061
24080062
24080063
42000020
24080065
@080
24080080
24080081
24080082
24080083
24080084
24080085
24080086
24080087

//--- verilog/fetchIf.sv
`timescale 1ns/10ps

interface fetchIf;

    logic [31:0] pc;
    logic [31:0] instruction;
    // pc and instruction only mean something while bubble is low
    logic        bubble;
    logic        exception;

    modport source (
        output pc,
        output instruction,
        output bubble,
        output exception
    );

    modport sink (
        input pc,
        input instruction,
        input bubble,
        input exception
    );

endinterface

//--- verilog/fetchPkg.sv
package fetchPkg;

    // first fetch after reset
    localparam logic [31:0] resetVector = 32'hBFC0_0000;

    // instruction memory geometry
    localparam int memWords = 1024;
    localparam int memIndexBits = $clog2(memWords);

    // a request outside the current line pays one fill cycle
    localparam int lineBytes = 64;
    localparam int lineOffsetBits = $clog2(lineBytes);

    // full encoding, cop0 opcode with the co bit and WAIT function
    localparam logic [31:0] waitInstruction = 32'h4200_0020;

    // primary opcode field, instruction bits 31:26
    typedef enum logic [5:0] {
        opSpecial = 6'b000000,
        opJ       = 6'b000010,
        opJal     = 6'b000011,
        opCop0    = 6'b010000
    } opcodeT;

endpackage

//--- verilog/fetchSubsystem.sv
`timescale 1ns/10ps

module fetchSubsystem (
    input  logic        clk,
    input  logic        reset,
    input  logic        pcStall,
    input  logic        redirect,
    input  logic [31:0] redirectAddress,
    output logic [31:0] fetchPc,
    output logic [31:0] fetchInstruction,
    output logic        fetchValid,
    output logic        fetchException
);

    logic        absJump;
    logic        hang;
    logic [31:0] absJumpAddress;

    sramIf  sramBus ();
    fetchIf fetchBus ();

    instructionFetch control (
        .clk            (clk),
        .reset          (reset),
        .absJump        (absJump),
        .hang           (hang),
        .absJumpAddress (absJumpAddress),
        .pcStall        (pcStall),
        .mem            (sramBus.master),
        .out            (fetchBus.source)
    );

    instSram memory (
        .clk   (clk),
        .reset (reset),
        .mem   (sramBus.slave)
    );

    // jump and hang requests go back to control on plain wires
    jumpPredecoder predecode (
        .clk              (clk),
        .reset            (reset),
        .in               (fetchBus.sink),
        .redirect         (redirect),
        .redirectAddress  (redirectAddress),
        .absJump          (absJump),
        .hang             (hang),
        .absJumpAddress   (absJumpAddress),
        .fetchPc          (fetchPc),
        .fetchInstruction (fetchInstruction),
        .fetchValid       (fetchValid),
        .fetchException   (fetchException)
    );

endmodule

//--- verilog/instSram.sv
`timescale 1ns/10ps

module instSram (
    input logic  clk,
    input logic  reset,
    sramIf.slave mem
);
    import fetchPkg::*;

    logic [31:0]               memory [memWords];
    logic [memIndexBits-1:0]   readIndex;
    logic [31-lineOffsetBits:0] lastLine;
    logic                      lineValid;
    logic                      lineHit;
    logic                      respValid;

    initial begin
        $readmemh("verification/program.hex", memory);
    end

    // same line as the request before it
    assign lineHit = lineValid && (mem.addr[31:lineOffsetBits] == lastLine);

    // address registered, word read out the cycle after
    always_ff @(posedge clk) begin
        if (mem.readEn) begin
            readIndex <= mem.addr[memIndexBits+1:2];
            lastLine <= mem.addr[31:lineOffsetBits];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            lineValid <= 1'b0;
            respValid <= 1'b0;
        end else begin
            // a miss answers with valid low, the repeated request then hits
            respValid <= mem.readEn && lineHit;
            if (mem.readEn) begin
                lineValid <= 1'b1;
            end
        end
    end

    assign mem.rdata = memory[readIndex];
    assign mem.valid = respValid;

endmodule

//--- verilog/instructionFetch.sv
`timescale 1ns/10ps

module instructionFetch (
    input  logic        clk,
    input  logic        reset,
    input  logic        absJump,
    input  logic        hang,
    input  logic [31:0] absJumpAddress,
    input  logic        pcStall,
    sramIf.master       mem,
    fetchIf.source      out
);
    import fetchPkg::*;

    logic [31:0] pc;
    logic [31:0] nextPc;
    logic        hangState;
    logic        isHanging;
    logic        hold;
    logic        pendingJump;
    logic [31:0] pendingJumpAddress;
    logic        takeJump;

    // pc stays put while stalled or while memory has nothing for it
    assign hold = pcStall || !mem.valid;
    assign isHanging = hang || hangState;

    // a jump is taken once the pc is free to move
    assign takeJump = !hold && (absJump || pendingJump);

    // always reading, the request is simply the next pc
    assign mem.readEn = 1'b1;
    assign mem.addr = nextPc;

    assign out.pc = isHanging ? 32'd0 : pc;
    assign out.instruction = isHanging ? 32'd0 : mem.rdata;
    // the stalled word comes again afterwards, so it is not passed on now
    assign out.bubble = isHanging || hold;
    assign out.exception = !isHanging && (pc[1:0] != 2'b00);

    always_comb begin
        if (hold) begin
            nextPc = pc;
        end else if (absJump) begin
            nextPc = absJumpAddress;
        end else if (pendingJump) begin
            nextPc = pendingJumpAddress;
        end else if (isHanging) begin
            nextPc = pc;
        end else begin
            nextPc = pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= resetVector;
            hangState <= 1'b0;
            pendingJump <= 1'b0;
        end else begin
            pc <= nextPc;

            // only a jump or redirect ends the hang
            if (takeJump) begin
                hangState <= 1'b0;
            end else if (hang) begin
                hangState <= 1'b1;
            end

            // jump arrived while waiting on the delay slot word
            if (absJump && hold) begin
                pendingJump <= 1'b1;
            end else if (!hold) begin
                pendingJump <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (absJump && hold) begin
            pendingJumpAddress <= absJumpAddress;
        end
    end

endmodule

//--- verilog/jumpPredecoder.sv
`timescale 1ns/10ps

module jumpPredecoder (
    input  logic        clk,
    input  logic        reset,
    fetchIf.sink        in,
    input  logic        redirect,
    input  logic [31:0] redirectAddress,
    output logic        absJump,
    output logic        hang,
    output logic [31:0] absJumpAddress,
    output logic [31:0] fetchPc,
    output logic [31:0] fetchInstruction,
    output logic        fetchValid,
    output logic        fetchException
);
    import fetchPkg::*;

    logic        validQ;
    logic [31:0] pcQ;
    logic [31:0] instructionQ;
    logic        exceptionQ;
    opcodeT      opcode;
    logic        isJump;
    logic        isWait;
    logic [31:0] pcPlus4;
    logic [31:0] jumpTarget;

    always_ff @(posedge clk) begin
        if (reset) begin
            validQ <= 1'b0;
        end else begin
            validQ <= !in.bubble;
        end
    end

    always_ff @(posedge clk) begin
        if (!in.bubble) begin
            pcQ <= in.pc;
            instructionQ <= in.instruction;
            exceptionQ <= in.exception;
        end
    end

    assign opcode = opcodeT'(instructionQ[31:26]);

    always_comb begin
        isJump = 1'b0;
        isWait = 1'b0;
        case (opcode)
            opJ, opJal: isJump = validQ;
            opCop0: isWait = validQ && (instructionQ == waitInstruction);
            default: isJump = 1'b0;
        endcase
    end

    // region of the delay slot, then the word index
    assign pcPlus4 = pcQ + 32'd4;
    assign jumpTarget = {pcPlus4[31:28], instructionQ[25:0], 2'b00};

    // exception vector or return wins over the decoded jump
    assign absJump = redirect || isJump;
    assign absJumpAddress = redirect ? redirectAddress : jumpTarget;
    assign hang = isWait && !redirect;

    assign fetchPc = pcQ;
    assign fetchInstruction = instructionQ;
    assign fetchValid = validQ;
    assign fetchException = exceptionQ;

endmodule

//--- verilog/sramIf.sv
`timescale 1ns/10ps

interface sramIf;

    logic [31:0] addr;
    logic        readEn;
    // word for the address of the previous cycle, or one later on a fill
    logic [31:0] rdata;
    logic        valid;

    modport master (
        output addr,
        output readEn,
        input  rdata,
        input  valid
    );

    modport slave (
        input  addr,
        input  readEn,
        output rdata,
        output valid
    );

endinterface
